// File: rename_pkg.sv
`default_nettype none

package rename_pkg;

  // register file sizes
  localparam int NUM_ARCH_REG = 16;
  localparam int NUM_PHYS_REG = 32;

  // index and counter widths
  localparam int ARCH_IDX_W = $clog2(NUM_ARCH_REG);
  localparam int PHYS_IDX_W = $clog2(NUM_PHYS_REG);
  localparam int FREE_CNT_W = PHYS_IDX_W + 1;

  // physical registers not bound to an architectural one at reset
  localparam int NUM_FREE_INIT = NUM_PHYS_REG - NUM_ARCH_REG;

  localparam int PC_W = 32;

  typedef logic [ARCH_IDX_W-1:0] arch_idx_t;
  typedef logic [PHYS_IDX_W-1:0] phys_idx_t;

  // op as it leaves the decoder
  typedef struct packed {
    logic [PC_W-1:0] pc;
    arch_idx_t       src1;
    arch_idx_t       src2;
    arch_idx_t       dest;
    logic            w_v;
    logic            is_branch;
  } decoded_uop_t;

  // op toward issue, all operands physical
  typedef struct packed {
    logic [PC_W-1:0] pc;
    phys_idx_t       psrc1;
    phys_idx_t       psrc2;
    phys_idx_t       pdest;
    logic            w_v;
    logic            is_branch;
  } renamed_uop_t;

  // reorder buffer entry, enough to commit or undo the rename
  typedef struct packed {
    logic [PC_W-1:0] pc;
    logic            w_v;
    logic            is_branch;
    arch_idx_t       arch_dest;
    phys_idx_t       alloc_preg;
    phys_idx_t       freed_preg;
  } rob_entry_t;

  // retiring op as seen by rename
  typedef struct packed {
    logic      w_v;
    arch_idx_t arch_dest;
    phys_idx_t alloc_preg;
    phys_idx_t freed_preg;
  } commit_t;

endpackage

`default_nettype wire

// File: rename_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rename_ctrl
  (
    // decode side
    input  logic decoded_v_i,
    input  logic w_v_i,
    input  logic free_avail_i,

    // commit side
    input  logic commit_v_i,
    input  logic commit_w_v_i,
    input  logic mispredict_i,

    // downstream ready levels
    input  logic issue_ready_i,
    input  logic rob_ready_i,

    output logic decode_ready_o,
    output logic fire_o,
    output logic alloc_o,
    output logic commit_free_o,
    output logic rollback_o,
    output logic issue_hold_o,
    output logic rob_hold_o
  );

  logic rollback;
  logic decode_ready;
  logic fire;

  // a mispredicting commit flushes all speculative state
  assign rollback = commit_v_i & mispredict_i;

  // need a free register and room on both outputs, and no flush in progress
  assign decode_ready = free_avail_i & ~rollback & issue_ready_i & rob_ready_i;

  assign fire = decoded_v_i & decode_ready;

  assign decode_ready_o = decode_ready;
  assign fire_o         = fire;
  assign alloc_o        = fire & w_v_i;

  // committed state only moves on a plain retire
  assign commit_free_o  = commit_v_i & commit_w_v_i & ~rollback;
  assign rollback_o     = rollback;

  // each output stalls on its own consumer
  assign issue_hold_o   = ~issue_ready_i;
  assign rob_hold_o     = ~rob_ready_i;

endmodule

`default_nettype wire

// File: rename_map_table.sv
`timescale 1ns/1ps
`default_nettype none

module rename_map_table
  (
    input  logic                 clk_i,
    input  logic                 reset_i,

    // lookups for the op being renamed
    input  rename_pkg::arch_idx_t src1_i,
    input  rename_pkg::arch_idx_t src2_i,
    input  rename_pkg::arch_idx_t dest_i,

    // speculative destination update
    input  logic                 alloc_i,
    input  rename_pkg::phys_idx_t alloc_preg_i,

    // committed update and flush
    input  logic                 commit_free_i,
    input  rename_pkg::commit_t   commit_i,
    input  logic                 rollback_i,

    output rename_pkg::phys_idx_t psrc1_o,
    output rename_pkg::phys_idx_t psrc2_o,
    output rename_pkg::phys_idx_t prev_preg_o
  );

  import rename_pkg::*;

  phys_idx_t spec_map_q [NUM_ARCH_REG];
  phys_idx_t cmt_map_q [NUM_ARCH_REG];

  // lookups see the table as it stands before this edge
  assign psrc1_o     = spec_map_q[src1_i];
  assign psrc2_o     = spec_map_q[src2_i];
  assign prev_preg_o = spec_map_q[dest_i];

  // speculative table
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < NUM_ARCH_REG; i++)
      begin
        spec_map_q[i] <= PHYS_IDX_W'(i);
      end
    end
    else if (rollback_i)
    begin
      spec_map_q <= cmt_map_q;
    end
    else if (alloc_i)
    begin
      spec_map_q[dest_i] <= alloc_preg_i;
    end
  end

  // committed table, follows retirement order
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < NUM_ARCH_REG; i++)
      begin
        cmt_map_q[i] <= PHYS_IDX_W'(i);
      end
    end
    else if (commit_free_i)
    begin
      cmt_map_q[commit_i.arch_dest] <= commit_i.alloc_preg;
    end
  end

endmodule

`default_nettype wire

// File: rename_free_list.sv
`timescale 1ns/1ps
`default_nettype none

module rename_free_list
  (
    input  logic                 clk_i,
    input  logic                 reset_i,

    input  logic                 alloc_i,
    input  logic                 commit_free_i,
    input  rename_pkg::phys_idx_t freed_preg_i,
    input  logic                 rollback_i,

    output rename_pkg::phys_idx_t head_preg_o,
    output logic                 free_avail_o
  );

  import rename_pkg::*;

  // speculative side
  phys_idx_t             spec_fl_q [NUM_PHYS_REG];
  phys_idx_t             spec_rd_ptr_q;
  phys_idx_t             spec_wr_ptr_q;
  logic [FREE_CNT_W-1:0] spec_cnt_q;

  // committed side
  phys_idx_t             cmt_fl_q [NUM_PHYS_REG];
  phys_idx_t             cmt_rd_ptr_q;
  phys_idx_t             cmt_wr_ptr_q;

  assign head_preg_o  = spec_fl_q[spec_rd_ptr_q];
  assign free_avail_o = (spec_cnt_q != '0);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      // slots 0..15 hold registers 16..31, the rest is unused
      for (int i = 0; i < NUM_PHYS_REG; i++)
      begin
        spec_fl_q[i] <= PHYS_IDX_W'(i + NUM_FREE_INIT);
      end
      spec_rd_ptr_q <= '0;
      spec_wr_ptr_q <= PHYS_IDX_W'(NUM_FREE_INIT);
      spec_cnt_q    <= FREE_CNT_W'(NUM_FREE_INIT);
    end
    else if (rollback_i)
    begin
      // committed list always holds exactly NUM_FREE_INIT entries
      spec_fl_q     <= cmt_fl_q;
      spec_rd_ptr_q <= cmt_rd_ptr_q;
      spec_wr_ptr_q <= cmt_wr_ptr_q;
      spec_cnt_q    <= FREE_CNT_W'(NUM_FREE_INIT);
    end
    else
    begin
      if (alloc_i)
      begin
        spec_rd_ptr_q <= spec_rd_ptr_q + 1'b1;
      end
      if (commit_free_i)
      begin
        spec_fl_q[spec_wr_ptr_q] <= freed_preg_i;
        spec_wr_ptr_q            <= spec_wr_ptr_q + 1'b1;
      end
      // alloc and free in one cycle cancel out
      spec_cnt_q <= spec_cnt_q + FREE_CNT_W'(commit_free_i) - FREE_CNT_W'(alloc_i);
    end
  end

  // committed list: each retire pops its own alloc and pushes the replaced reg
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < NUM_PHYS_REG; i++)
      begin
        cmt_fl_q[i] <= PHYS_IDX_W'(i + NUM_FREE_INIT);
      end
      cmt_rd_ptr_q <= '0;
      cmt_wr_ptr_q <= PHYS_IDX_W'(NUM_FREE_INIT);
    end
    else if (commit_free_i)
    begin
      cmt_fl_q[cmt_wr_ptr_q] <= freed_preg_i;
      cmt_wr_ptr_q           <= cmt_wr_ptr_q + 1'b1;
      cmt_rd_ptr_q           <= cmt_rd_ptr_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: rename_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module rename_pipe_reg
  #(
    parameter type payload_t = logic
  )
  (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     load_i,
    input  logic     hold_i,
    input  payload_t data_i,
    output payload_t data_o,
    output logic     valid_o
  );

  payload_t data_q;
  logic     valid_q;

  always_ff @(posedge clk_i)
  begin
    if (!hold_i)
    begin
      data_q <= data_i;
    end
  end

  // consumer stalled, keep presenting the same entry
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      valid_q <= 1'b0;
    end
    else if (!hold_i)
    begin
      valid_q <= load_i;
    end
  end

  assign data_o  = data_q;
  assign valid_o = valid_q;

endmodule

`default_nettype wire

// File: rename_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rename_unit
  (
    input  logic                     clk_i,
    input  logic                     reset_i,

    // decode side
    input  rename_pkg::decoded_uop_t decoded_i,
    input  logic                     decoded_v_i,
    output logic                     decode_ready_o,

    // issue side
    output rename_pkg::renamed_uop_t renamed_o,
    output logic                     renamed_v_o,
    input  logic                     issue_ready_i,

    // reorder buffer side
    output rename_pkg::rob_entry_t   rob_entry_o,
    output logic                     rob_entry_v_o,
    input  logic                     rob_ready_i,

    // commit side
    input  logic                     commit_v_i,
    input  rename_pkg::commit_t      commit_i,
    input  logic                     mispredict_i
  );

  import rename_pkg::*;

  logic         fire;
  logic         alloc;
  logic         commit_free;
  logic         rollback;
  logic         issue_hold;
  logic         rob_hold;
  logic         free_avail;
  phys_idx_t    psrc1;
  phys_idx_t    psrc2;
  phys_idx_t    prev_preg;
  phys_idx_t    head_preg;
  phys_idx_t    new_preg;
  renamed_uop_t renamed_d;
  rob_entry_t   rob_entry_d;

  rename_ctrl rename_ctrl_inst (
    .decoded_v_i    (decoded_v_i),
    .w_v_i          (decoded_i.w_v),
    .free_avail_i   (free_avail),
    .commit_v_i     (commit_v_i),
    .commit_w_v_i   (commit_i.w_v),
    .mispredict_i   (mispredict_i),
    .issue_ready_i  (issue_ready_i),
    .rob_ready_i    (rob_ready_i),
    .decode_ready_o (decode_ready_o),
    .fire_o         (fire),
    .alloc_o        (alloc),
    .commit_free_o  (commit_free),
    .rollback_o     (rollback),
    .issue_hold_o   (issue_hold),
    .rob_hold_o     (rob_hold)
  );

  rename_map_table rename_map_table_inst (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .src1_i        (decoded_i.src1),
    .src2_i        (decoded_i.src2),
    .dest_i        (decoded_i.dest),
    .alloc_i       (alloc),
    .alloc_preg_i  (head_preg),
    .commit_free_i (commit_free),
    .commit_i      (commit_i),
    .rollback_i    (rollback),
    .psrc1_o       (psrc1),
    .psrc2_o       (psrc2),
    .prev_preg_o   (prev_preg)
  );

  rename_free_list rename_free_list_inst (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .alloc_i       (alloc),
    .commit_free_i (commit_free),
    .freed_preg_i  (commit_i.freed_preg),
    .rollback_i    (rollback),
    .head_preg_o   (head_preg),
    .free_avail_o  (free_avail)
  );

  // non-writing ops carry no destination
  assign new_preg = decoded_i.w_v ? head_preg : '0;

  always_comb
  begin
    renamed_d.pc        = decoded_i.pc;
    renamed_d.psrc1     = psrc1;
    renamed_d.psrc2     = psrc2;
    renamed_d.pdest     = new_preg;
    renamed_d.w_v       = decoded_i.w_v;
    renamed_d.is_branch = decoded_i.is_branch;
  end

  always_comb
  begin
    rob_entry_d.pc         = decoded_i.pc;
    rob_entry_d.w_v        = decoded_i.w_v;
    rob_entry_d.is_branch  = decoded_i.is_branch;
    rob_entry_d.arch_dest  = decoded_i.dest;
    rob_entry_d.alloc_preg = new_preg;
    // register to release once this op retires
    rob_entry_d.freed_preg = prev_preg;
  end

  rename_pipe_reg #(
    .payload_t (renamed_uop_t)
  ) issue_reg_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .load_i  (fire),
    .hold_i  (issue_hold),
    .data_i  (renamed_d),
    .data_o  (renamed_o),
    .valid_o (renamed_v_o)
  );

  rename_pipe_reg #(
    .payload_t (rob_entry_t)
  ) rob_reg_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .load_i  (fire),
    .hold_i  (rob_hold),
    .data_i  (rob_entry_d),
    .data_o  (rob_entry_o),
    .valid_o (rob_entry_v_o)
  );

endmodule

`default_nettype wire

// File: tb_rename_model.svh
`ifndef TB_RENAME_MODEL_SVH
`define TB_RENAME_MODEL_SVH

  // alias tables, speculative and committed
  phys_idx_t  spec_map [NUM_ARCH_REG];
  phys_idx_t  cmt_map [NUM_ARCH_REG];

  // free lists, next register to hand out at the front
  phys_idx_t  spec_free [$];
  phys_idx_t  cmt_free [$];

  // renamed ops waiting to retire, oldest first
  rob_entry_t in_flight [$];

  function automatic void init_tables();
    spec_free.delete();
    cmt_free.delete();
    in_flight.delete();
    for (int i = 0; i < NUM_ARCH_REG; i++)
    begin
      spec_map[i] = phys_idx_t'(i);
      cmt_map[i]  = phys_idx_t'(i);
    end
    for (int i = NUM_ARCH_REG; i < NUM_PHYS_REG; i++)
    begin
      spec_free.push_back(phys_idx_t'(i));
      cmt_free.push_back(phys_idx_t'(i));
    end
  endfunction

  function automatic void take_free_reg(input arch_idx_t dest, input phys_idx_t preg);
    void'(spec_free.pop_front());
    spec_map[dest] = preg;
  endfunction

  function automatic void retire_op(input commit_t c, input logic mis);
    if (mis)
    begin
      // flush back to the retired state
      spec_map  = cmt_map;
      spec_free = cmt_free;
      in_flight.delete();
    end
    else if (c.w_v)
    begin
      cmt_map[c.arch_dest] = c.alloc_preg;
      void'(cmt_free.pop_front());
      cmt_free.push_back(c.freed_preg);
      spec_free.push_back(c.freed_preg);
    end
  endfunction

`endif

// File: tb_rename_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rename_unit;

  import rename_pkg::*;

  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 5;
  localparam int DIRECTED_CYCLES = 20;
  localparam int RANDOM_CYCLES   = 2000;
  localparam int TIMEOUT_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 75;
  localparam int SEED            = 87753;

  logic         clk_i;
  logic         reset_i;
  decoded_uop_t decoded_i;
  logic         decoded_v_i;
  logic         decode_ready_o;
  renamed_uop_t renamed_o;
  logic         renamed_v_o;
  logic         issue_ready_i;
  rob_entry_t   rob_entry_o;
  logic         rob_entry_v_o;
  logic         rob_ready_i;
  logic         commit_v_i;
  commit_t      commit_i;
  logic         mispredict_i;

  // what both output registers should hold after the last edge
  renamed_uop_t exp_ren;
  logic         exp_ren_v;
  rob_entry_t   exp_rob;
  logic         exp_rob_v;
  int           checks;
  int           errors;

  `include "tb_rename_model.svh"

  rename_unit rename_unit_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .decoded_i      (decoded_i),
    .decoded_v_i    (decoded_v_i),
    .decode_ready_o (decode_ready_o),
    .renamed_o      (renamed_o),
    .renamed_v_o    (renamed_v_o),
    .issue_ready_i  (issue_ready_i),
    .rob_entry_o    (rob_entry_o),
    .rob_entry_v_o  (rob_entry_v_o),
    .rob_ready_i    (rob_ready_i),
    .commit_v_i     (commit_v_i),
    .commit_i       (commit_i),
    .mispredict_i   (mispredict_i)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic compare_field(input string name, input logic [63:0] got,
                               input logic [63:0] want);
    checks++;
    assert (got === want)
    else
    begin
      errors++;
      $display("error: %0t ns %s expected 0x%0h got 0x%0h", $time, name, want, got);
    end
  endtask

  task automatic check_outputs();
    compare_field("renamed_v_o", 64'(renamed_v_o), 64'(exp_ren_v));
    compare_field("rob_entry_v_o", 64'(rob_entry_v_o), 64'(exp_rob_v));
    if (exp_ren_v)
    begin
      compare_field("renamed_o", 64'(renamed_o), 64'(exp_ren));
    end
    if (exp_rob_v)
    begin
      compare_field("rob_entry_o", 64'(rob_entry_o), 64'(exp_rob));
    end
  endtask

  // one clock that checks the last edge, drives at the falling edge and predicts the next
  task automatic step_cycle(input logic dec_v, input decoded_uop_t uop, input logic iss_rdy,
                            input logic rob_rdy, input logic do_commit, input logic mispred);
    commit_t      cm;
    rob_entry_t   oldest;
    logic         took;
    logic         mis;
    logic         exp_ready;
    logic         fire;
    renamed_uop_t ren;
    rob_entry_t   ent;
    @(negedge clk_i);
    check_outputs();
    // idle cycles carry a random commit payload
    cm   = $bits(commit_t)'($urandom);
    took = 1'b0;
    mis  = 1'b0;
    if (do_commit && in_flight.size() > 0)
    begin
      oldest       = in_flight.pop_front();
      took         = 1'b1;
      cm.w_v       = oldest.w_v;
      cm.arch_dest = oldest.arch_dest;
      cm.alloc_preg = oldest.alloc_preg;
      cm.freed_preg = oldest.freed_preg;
      mis          = mispred && oldest.is_branch;
    end
    decoded_i     = uop;
    decoded_v_i   = dec_v;
    issue_ready_i = iss_rdy;
    rob_ready_i   = rob_rdy;
    commit_v_i    = took;
    commit_i      = cm;
    // mispredict level may also be high without a commit
    mispredict_i  = took ? mis : mispred;
    #1;
    exp_ready = (spec_free.size() > 0) && !mis && iss_rdy && rob_rdy;
    compare_field("decode_ready_o", 64'(decode_ready_o), 64'(exp_ready));
    fire = dec_v && exp_ready;

    // lookups use the state before this edge
    ren.pc        = uop.pc;
    ren.psrc1     = spec_map[uop.src1];
    ren.psrc2     = spec_map[uop.src2];
    ren.pdest     = (uop.w_v && spec_free.size() > 0) ? spec_free[0] : '0;
    ren.w_v       = uop.w_v;
    ren.is_branch = uop.is_branch;
    ent.pc         = uop.pc;
    ent.w_v        = uop.w_v;
    ent.is_branch  = uop.is_branch;
    ent.arch_dest  = uop.dest;
    ent.alloc_preg = ren.pdest;
    ent.freed_preg = spec_map[uop.dest];

    if (fire && uop.w_v)
    begin
      take_free_reg(uop.dest, ren.pdest);
    end
    if (took)
    begin
      retire_op(cm, mis);
    end
    if (fire)
    begin
      in_flight.push_back(ent);
    end
    if (iss_rdy)
    begin
      exp_ren_v = fire;
      exp_ren   = ren;
    end
    if (rob_rdy)
    begin
      exp_rob_v = fire;
      exp_rob   = ent;
    end
  endtask

  initial
  begin
    decoded_uop_t uop;
    logic         dec_v;
    logic         iss_rdy;
    logic         rob_rdy;
    logic         do_commit;
    logic         mispred;
    void'($urandom(SEED));
    reset_i       = 1'b1;
    decoded_i     = '0;
    decoded_v_i   = 1'b0;
    issue_ready_i = 1'b1;
    rob_ready_i   = 1'b1;
    commit_v_i    = 1'b0;
    commit_i      = '0;
    mispredict_i  = 1'b0;
    checks        = 0;
    errors        = 0;
    exp_ren       = '0;
    exp_ren_v     = 1'b0;
    exp_rob       = '0;
    exp_rob_v     = 1'b0;
    init_tables();
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    #1;
    compare_field("decode_ready_o", 64'(decode_ready_o), 64'(1));
    compare_field("renamed_v_o", 64'(renamed_v_o), 64'(0));
    compare_field("rob_entry_v_o", 64'(rob_entry_v_o), 64'(0));

    // use up every free register with no commits
    for (int k = 0; k < NUM_FREE_INIT; k++)
    begin
      uop        = '0;
      uop.pc     = 32'h1000 + 32'(4 * k);
      uop.src1   = arch_idx_t'(k);
      uop.src2   = arch_idx_t'(k + 1);
      uop.dest   = arch_idx_t'(NUM_ARCH_REG - 1 - k);
      uop.w_v    = 1'b1;
      step_cycle(1'b1, uop, 1'b1, 1'b1, 1'b0, 1'b0);
      if (k == 0)
      begin
        @(posedge clk_i);
        #1;
        // first free register right after the identity-mapped ones
        compare_field("renamed_o.pdest", 64'(renamed_o.pdest), 64'(NUM_ARCH_REG));
        compare_field("rob_entry_o.freed_preg", 64'(rob_entry_o.freed_preg),
                      64'(NUM_ARCH_REG - 1));
      end
    end
    step_cycle(1'b1, uop, 1'b1, 1'b1, 1'b0, 1'b0);
    compare_field("decode_ready_o", 64'(decode_ready_o), 64'(0));
    step_cycle(1'b0, uop, 1'b1, 1'b1, 1'b1, 1'b0);
    step_cycle(1'b1, uop, 1'b1, 1'b1, 1'b0, 1'b0);
    compare_field("decode_ready_o", 64'(decode_ready_o), 64'(1));

    for (int n = 0; n < RANDOM_CYCLES; n++)
    begin
      uop.pc        = $urandom;
      uop.src1      = arch_idx_t'($urandom);
      uop.src2      = arch_idx_t'($urandom);
      uop.dest      = arch_idx_t'($urandom);
      uop.is_branch = ($urandom % 6 == 0);
      uop.w_v       = !uop.is_branch && ($urandom % 4 != 0);
      dec_v         = ($urandom % 4 != 0);
      iss_rdy       = ($urandom % 5 != 0);
      rob_rdy       = ($urandom % 5 != 0);
      do_commit     = ($urandom % 2 == 0);
      mispred       = ($urandom % 4 == 0);
      step_cycle(dec_v, uop, iss_rdy, rob_rdy, do_commit, mispred);
    end
    @(negedge clk_i);
    check_outputs();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  end

  // watchdog
  initial
  begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
rename_pkg.sv
rename_ctrl.sv
rename_map_table.sv
rename_free_list.sv
rename_pipe_reg.sv
rename_unit.sv
tb_rename_unit.sv

// File: Makefile
# Verilator flow for the rename stage testbench

LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 -f build.f --top-module tb_rename_unit
	./obj_dir/Vtb_rename_unit | tee $(LOG)
	grep -qx "test passed" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module tb_rename_unit

clean:
	rm -rf obj_dir $(LOG)
